//--- rv_core.f
+incdir+design
design/rv_core_pkg.sv
design/rv_mem_port.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_exec_unit.sv
design/rv_control.sv
design/rv_core.sv
tb/tb_memory.sv
tb/rv_core_tb.sv

//--- tb/rv_core_tb.sv
// RV32I core testbench
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_core_tb import rv_core_pkg::*; ();
	logic clk;
	logic resetn;
	logic mem_valid;
	mem_req_t mem_req;
	logic mem_ready;
	logic [`RV_XLEN-1:0] mem_rdata;
	logic trap;

	string names[$];
	int prog_start[$];
	int prog_len[$];
	int exp_start[$];
	int exp_len[$];
	logic [31:0] prog[$];
	logic [31:0] sig[$];
	int cycle_count;
	int cycle_limit;
	int failed;
	int total_errors;

	rv_core u_dut (.*);

	tb_memory #(.seed(32'hbbc5c8e7)) u_mem (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Instruction encoders
	function automatic logic [31:0] r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
			int rd);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RV_OPC_OP};
	endfunction

	function automatic logic [31:0] i_type(int imm, int rs1, logic [2:0] f3, int rd,
			logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
	endfunction

	function automatic logic [31:0] s_type(int imm, int rs2, int rs1, logic [2:0] f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], `RV_OPC_STORE};
	endfunction

	function automatic logic [31:0] b_type(int imm, int rs2, int rs1, logic [2:0] f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `RV_OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(int imm20, int rd, logic [6:0] opc);
		return {imm20[19:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] j_type(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RV_OPC_JAL};
	endfunction

	function automatic logic [31:0] addi(int rd, int rs1, int imm);
		return i_type(imm, rs1, 3'd0, rd, `RV_OPC_OPIMM);
	endfunction

	task automatic open_test(input string name);
		names.push_back(name);
		prog_start.push_back(prog.size());
		exp_start.push_back(sig.size());
		// x10 points at the signature area
		prog.push_back(addi(10, 0, 256));
	endtask

	task automatic close_test();
		prog.push_back(32'h0);
		prog_len.push_back(prog.size() - prog_start[$]);
		exp_len.push_back(sig.size() - exp_start[$]);
	endtask

	task automatic store_nine(input int r[9], input int off);
		for (int k = 0; k < 9; k++)
			prog.push_back(s_type(off + 4*k, r[k], 10, 3'd2));
	endtask

	task automatic build_table();
		int alu_regs[9] = '{3, 4, 5, 6, 7, 8, 9, 11, 12};
		int sh_regs[9] = '{5, 6, 7, 8, 9, 11, 12, 13, 14};
		int ld_regs[9] = '{4, 5, 6, 7, 8, 9, 11, 12, 13};
		int br_f3[12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
		int br_rs1[12] = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 2, 1};
		int br_rs2[12] = '{2, 2, 2, 2, 2, 1, 1, 2, 1, 2, 1, 2};
		logic [31:0] faults[4];
		string fault_names[4] = '{"illegal", "rdcycle", "misaligned_lw", "misaligned_jmp"};

		open_test("alu");
		prog = {prog, addi(1, 0, -5), addi(2, 0, 7), r_type(0, 2, 1, 0, 3),
			r_type(`RV_F7_ALT, 1, 2, 0, 4), r_type(0, 2, 1, 4, 5), r_type(0, 2, 1, 6, 6),
			r_type(0, 2, 1, 7, 7), r_type(0, 2, 1, 2, 8), r_type(0, 2, 1, 3, 9),
			i_type(-1, 2, 3'd2, 11, `RV_OPC_OPIMM), i_type(-1, 2, 3'd3, 12, `RV_OPC_OPIMM)};
		store_nine(alu_regs, 0);
		sig = {sig, 32'h2, 32'hc, 32'hffff_fffc, 32'hffff_ffff, 32'h3, 32'h1, 32'h0, 32'h0, 32'h1};
		close_test();

		open_test("shift");
		prog = {prog, u_type('h80001, 1, `RV_OPC_LUI), addi(1, 1, 'h234), addi(2, 0, 3),
			addi(3, 0, 4), addi(4, 0, 31), r_type(0, 0, 1, 1, 5), r_type(0, 2, 1, 1, 6),
			r_type(0, 3, 1, 5, 7), r_type(`RV_F7_ALT, 3, 1, 5, 8), r_type(0, 4, 1, 5, 9),
			r_type(`RV_F7_ALT, 4, 1, 5, 11), r_type(0, 4, 1, 1, 12),
			r_type(`RV_F7_ALT, 2, 1, 5, 13), i_type('h405, 1, 3'd5, 14, `RV_OPC_OPIMM)};
		store_nine(sh_regs, 0);
		sig = {sig, 32'h8000_1234, 32'h0000_91a0, 32'h0800_0123, 32'hf800_0123, 32'h1,
			32'hffff_ffff, 32'h0, 32'hf000_0246, 32'hfc00_0091};
		close_test();

		open_test("memory");
		prog = {prog, u_type('h12345, 1, `RV_OPC_LUI), addi(1, 1, 'h678), addi(2, 0, -1),
			addi(3, 0, 'ha5), s_type(0, 1, 10, 3'd2), s_type(5, 3, 10, 3'd0),
			s_type(7, 2, 10, 3'd0), s_type(4, 1, 10, 3'd0), s_type(6, 3, 10, 3'd0),
			s_type(8, 1, 10, 3'd1), s_type(10, 2, 10, 3'd1),
			i_type(7, 10, 3'd0, 4, `RV_OPC_LOAD), i_type(5, 10, 3'd4, 5, `RV_OPC_LOAD),
			i_type(5, 10, 3'd0, 6, `RV_OPC_LOAD), i_type(10, 10, 3'd1, 7, `RV_OPC_LOAD),
			i_type(8, 10, 3'd5, 8, `RV_OPC_LOAD), i_type(6, 10, 3'd1, 9, `RV_OPC_LOAD),
			i_type(0, 10, 3'd2, 11, `RV_OPC_LOAD), i_type(4, 10, 3'd4, 12, `RV_OPC_LOAD),
			i_type(2, 10, 3'd5, 13, `RV_OPC_LOAD)};
		store_nine(ld_regs, 12);
		sig = {sig, 32'h1234_5678, 32'hffa5_a578, 32'hffff_5678, 32'hffff_ffff, 32'h0000_00a5,
			32'hffff_ffa5, 32'hffff_ffff, 32'h0000_5678, 32'hffff_ffa5, 32'h1234_5678,
			32'h0000_0078, 32'h0000_1234};
		close_test();

		// Each taken branch skips the ori that would set its bit
		open_test("flow");
		prog = {prog, addi(1, 0, -1), addi(2, 0, 1), addi(6, 0, 0)};
		for (int i = 0; i < 12; i++) begin
			prog.push_back(b_type(8, br_rs2[i], br_rs1[i], br_f3[i][2:0]));
			prog.push_back(i_type(1 << i, 6, 3'd6, 6, `RV_OPC_OPIMM));
		end
		prog = {prog, s_type(0, 6, 10, 3'd2), j_type(8, 7), addi(7, 0, 0), s_type(4, 7, 10, 3'd2),
			u_type(0, 8, `RV_OPC_AUIPC), i_type(16, 8, 3'd0, 9, `RV_OPC_JALR), addi(9, 0, 0),
			addi(9, 0, 0), s_type(8, 8, 10, 3'd2), s_type(12, 9, 10, 3'd2),
			u_type('habcde, 11, `RV_OPC_LUI), s_type(16, 11, 10, 3'd2),
			u_type(1, 12, `RV_OPC_AUIPC), s_type(20, 12, 10, 3'd2)};
		sig = {sig, 32'h6aa, 32'h78, 32'h80, 32'h88, 32'habcd_e000, 32'h10a0};
		close_test();

		faults[0] = 32'hffff_ffff;
		faults[1] = 32'hc000_22f3;
		faults[2] = i_type(2, 10, 3'd2, 2, `RV_OPC_LOAD);
		faults[3] = j_type(6, 0);
		for (int f = 0; f < 4; f++) begin
			open_test(fault_names[f]);
			prog = {prog, addi(1, 0, 'h11), s_type(0, 1, 10, 3'd2), faults[f],
				s_type(4, 1, 10, 3'd2)};
			sig = {sig, 32'h11, 32'h0};
			close_test();
		end
	endtask

	task automatic run_test(input int t, output int errs);
		int n;
		logic late_req;
		logic [31:0] got;

		errs = 0;
		@(posedge clk);
		#1;
		resetn = 1'b0;
		for (int i = 0; i < 256; i++)
			u_mem.mem[i] = (i >= 64 && i < 96) ? 32'h0 : {i[23:0], 8'h00};
		for (int i = 0; i < prog_len[t]; i++)
			u_mem.mem[i] = prog[prog_start[t] + i];
		u_mem.stray_count = 0;
		u_mem.instr_errors = 0;
		repeat (10) @(posedge clk);
		#1;
		resetn = 1'b1;
		n = 0;
		while (!trap && n < prog_len[t] * 40) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!trap) begin
			$display("%s: trap was not raised within %0d cycles", names[t], n);
			errs++;
		end
		late_req = 1'b0;
		repeat (8) begin
			@(posedge clk);
			#1;
			late_req = late_req | mem_valid;
		end
		if (trap && late_req) begin
			$display("%s: memory request raised after trap", names[t]);
			errs++;
		end
		for (int k = 0; k < exp_len[t]; k++) begin
			got = u_mem.mem[64 + k];
			if (got !== sig[exp_start[t] + k]) begin
				$display("MISMATCH at %0t: mem[0x%h] got %h expected %h", $time, 32'h100 + 4*k,
					got, sig[exp_start[t] + k]);
				errs++;
			end
		end
		if (u_mem.stray_count != 0) begin
			$display("%s: write outside the signature area at 0x%h", names[t], u_mem.stray_addr);
			errs++;
		end
		errs += u_mem.instr_errors;
	endtask

	// Run limit scales with program size
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Run stopped after %0d cycles without finishing", cycle_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		int errs;

		resetn = 1'b0;
		cycle_count = 0;
		failed = 0;
		total_errors = 0;
		build_table();
		cycle_limit = prog.size() * 40 + names.size() * 30;
		for (int t = 0; t < names.size(); t++) begin
			run_test(t, errs);
			$display("test %0d %s: %s (%0d errors)", t, names[t], errs == 0 ? "passed" : "FAILED",
				errs);
			total_errors += errs;
			if (errs != 0)
				failed++;
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors", names.size(),
			names.size() - failed, failed, total_errors);
		if (failed == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- tb/tb_memory.sv
// Testbench memory model
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module tb_memory import rv_core_pkg::*; #(
	parameter logic [31:0] seed = 32'h1
) (
	input logic clk,
	input logic resetn,
	input logic mem_valid,
	input mem_req_t mem_req,
	output logic mem_ready,
	output logic [`RV_XLEN-1:0] mem_rdata
);
	logic [`RV_XLEN-1:0] mem [256];
	int stray_count;
	int instr_errors;
	logic [`RV_XLEN-1:0] stray_addr;
	logic seeded;
	logic armed;
	int wait_cnt;
	logic v_s;
	logic r_s;
	logic rst_s;
	mem_req_t req_s;

	task automatic write_word(input mem_req_t req);
		for (int b = 0; b < 4; b++) begin
			if (req.wstrb[b])
				mem[req.addr[9:2]][8*b +: 8] = req.wdata[8*b +: 8];
		end
		// Only the signature window may be written
		if (req.addr < 32'h100 || req.addr >= 32'h180) begin
			stray_count++;
			stray_addr = req.addr;
		end
	endtask

	initial begin
		mem_ready = 1'b0;
		mem_rdata = '0;
		seeded = 1'b0;
		armed = 1'b0;
		wait_cnt = 0;
		stray_count = 0;
		instr_errors = 0;
		stray_addr = '0;
	end

	always @(posedge clk) begin
		v_s = mem_valid;
		r_s = mem_ready;
		rst_s = resetn;
		req_s = mem_req;
		if (!seeded) begin
			seeded = 1'b1;
			void'($urandom(seed));
		end
		#1;
		if (!rst_s) begin
			mem_ready = 1'b0;
			armed = 1'b0;
		end else if (v_s && r_s) begin
			mem_ready = 1'b0;
			armed = 1'b0;
			// Program words sit below the signature area
			if (req_s.instr !== (req_s.addr < 32'h100)) begin
				$display("MISMATCH at %0t: mem_req.instr for 0x%h got %b expected %b", $time,
					req_s.addr, req_s.instr, req_s.addr < 32'h100);
				instr_errors++;
			end
			if (req_s.wstrb != '0)
				write_word(req_s);
		end else if (v_s) begin
			if (!armed) begin
				armed = 1'b1;
				wait_cnt = $urandom_range(3, 0);
			end
			if (wait_cnt == 0) begin
				mem_ready = 1'b1;
				mem_rdata = mem[req_s.addr[9:2]];
			end else begin
				wait_cnt--;
			end
		end
	end

endmodule

//--- design/rv_core.sv
// RV32I multi-cycle core top
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_core import rv_core_pkg::*; (
	input logic clk,
	input logic resetn,
	output logic mem_valid,
	output mem_req_t mem_req,
	input logic mem_ready,
	input logic [`RV_XLEN-1:0] mem_rdata,
	output logic trap
);
	logic dec_valid;
	dec_instr_t dec;
	logic cmd_start;
	mem_cmd_t cmd;
	logic busy;
	logic done;
	logic fetch_done;
	logic [`RV_XLEN-1:0] rdata;
	logic [`RV_REG_BITS-1:0] rs1;
	logic [`RV_REG_BITS-1:0] rs2;
	logic [`RV_XLEN-1:0] rs1_data;
	logic [`RV_XLEN-1:0] rs2_data;
	logic we;
	logic [`RV_REG_BITS-1:0] rd;
	logic [`RV_XLEN-1:0] rd_data;
	logic ex_start;
	alu_op_t alu_op;
	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;
	logic ex_done;
	logic [`RV_XLEN-1:0] result;

	rv_control u_control (.*);

	rv_mem_port u_mem_port (.*);

	// Fetched words come back through the load path
	rv_decoder u_decoder (
		.clk(clk),
		.resetn(resetn),
		.fetch_done(fetch_done),
		.fetched_word(rdata),
		.dec_valid(dec_valid),
		.dec(dec)
	);

	rv_regfile u_regfile (.*);

	rv_exec_unit u_exec_unit (.*);

endmodule

//--- design/rv_control.sv
// Core control FSM
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_control import rv_core_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic dec_valid,
	input dec_instr_t dec,
	output logic cmd_start,
	output mem_cmd_t cmd,
	input logic busy,
	input logic done,
	input logic [`RV_XLEN-1:0] rdata,
	output logic [`RV_REG_BITS-1:0] rs1,
	output logic [`RV_REG_BITS-1:0] rs2,
	input logic [`RV_XLEN-1:0] rs1_data,
	input logic [`RV_XLEN-1:0] rs2_data,
	output logic we,
	output logic [`RV_REG_BITS-1:0] rd,
	output logic [`RV_XLEN-1:0] rd_data,
	output logic ex_start,
	output alu_op_t alu_op,
	output logic [`RV_XLEN-1:0] op_a,
	output logic [`RV_XLEN-1:0] op_b,
	input logic ex_done,
	input logic [`RV_XLEN-1:0] result,
	output logic trap
);
	typedef enum logic [2:0] {st_fetch, st_dec_wait, st_exec, st_mem, st_wb} state_t;

	state_t state;
	logic [`RV_XLEN-1:0] pc;
	logic [`RV_XLEN-1:0] next_pc;
	logic [`RV_XLEN-1:0] target;
	logic [`RV_XLEN-1:0] addr_sum;
	logic [`RV_XLEN-1:0] opnd_a;
	logic [`RV_XLEN-1:0] opnd_b;
	logic base_is_rs1;
	logic data_misaligned;

	// Decoded fields stay valid until the next fetch completes
	assign rs1 = dec.rs1;
	assign rs2 = dec.rs2;
	assign rd = dec.rd;

	assign next_pc = pc + `RV_PC_STEP;
	assign base_is_rs1 = dec.kind inside {kind_jalr, kind_load, kind_store};
	assign addr_sum = (base_is_rs1 ? rs1_data : pc) + dec.imm;
	assign data_misaligned = (dec.mem_size == size_word && addr_sum[1:0] != 2'b00) ||
		(dec.mem_size == size_half && addr_sum[0]);

	always_comb begin
		case (dec.kind)
			kind_lui: opnd_a = '0;
			kind_auipc, kind_jal, kind_jalr: opnd_a = pc;
			default: opnd_a = rs1_data;
		endcase
		if (dec.kind == kind_jal || dec.kind == kind_jalr)
			opnd_b = `RV_XLEN'(`RV_PC_STEP);
		else
			opnd_b = dec.use_imm ? dec.imm : rs2_data;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= st_fetch;
			pc <= '0;
			trap <= 1'b0;
			cmd_start <= 1'b0;
			ex_start <= 1'b0;
			we <= 1'b0;
		end else begin
			cmd_start <= 1'b0;
			ex_start <= 1'b0;
			we <= 1'b0;
			case (state)
				st_fetch: begin
					if (!trap && !busy) begin
						if (pc[1:0] != 2'b00) begin
							trap <= 1'b1;
						end else begin
							cmd_start <= 1'b1;
							state <= st_dec_wait;
						end
					end
				end
				st_dec_wait: begin
					if (dec_valid) begin
						case (dec.kind)
							kind_illegal: begin
								trap <= 1'b1;
								state <= st_fetch;
							end
							kind_fence: begin
								pc <= next_pc;
								state <= st_fetch;
							end
							kind_load, kind_store: begin
								if (data_misaligned) begin
									trap <= 1'b1;
									state <= st_fetch;
								end else begin
									cmd_start <= 1'b1;
									state <= st_mem;
								end
							end
							default: begin
								ex_start <= 1'b1;
								state <= st_exec;
							end
						endcase
					end
				end
				st_exec: begin
					if (ex_done) begin
						if (dec.kind == kind_branch) begin
							pc <= result[0] ? target : next_pc;
							state <= st_fetch;
						end else begin
							pc <= (dec.kind inside {kind_jal, kind_jalr}) ? target : next_pc;
							we <= 1'b1;
							state <= st_wb;
						end
					end
				end
				st_mem: begin
					if (done) begin
						pc <= next_pc;
						if (cmd.sel == sel_load) begin
							we <= 1'b1;
							state <= st_wb;
						end else begin
							state <= st_fetch;
						end
					end
				end
				default: state <= st_fetch;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_fetch) begin
			cmd.sel <= sel_fetch;
			cmd.addr <= pc;
			cmd.wdata <= '0;
			cmd.mem_size <= size_word;
			cmd.load_unsigned <= 1'b0;
		end else if (state == st_dec_wait && dec_valid) begin
			cmd.sel <= (dec.kind == kind_store) ? sel_store : sel_load;
			cmd.addr <= addr_sum;
			cmd.wdata <= rs2_data;
			cmd.mem_size <= dec.mem_size;
			cmd.load_unsigned <= dec.load_unsigned;
			// jalr clears the low target bit
			target <= (dec.kind == kind_jalr) ? {addr_sum[`RV_XLEN-1:1], 1'b0} : addr_sum;
			alu_op <= dec.alu_op;
			op_a <= opnd_a;
			op_b <= opnd_b;
		end
		if (state == st_exec && ex_done)
			rd_data <= result;
		else if (state == st_mem && done)
			rd_data <= rdata;
	end

endmodule

//--- design/rv_exec_unit.sv
// ALU and iterative shifter
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_exec_unit import rv_core_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic ex_start,
	input alu_op_t alu_op,
	input logic [`RV_XLEN-1:0] op_a,
	input logic [`RV_XLEN-1:0] op_b,
	output logic ex_done,
	output logic [`RV_XLEN-1:0] result
);
	logic shifting;
	logic is_shift;
	logic [4:0] sh_cnt;
	logic [`RV_XLEN-1:0] sh_val;
	alu_op_t sh_op;
	logic [`RV_XLEN-1:0] alu_out;

	function automatic logic [`RV_XLEN-1:0] shift_by(alu_op_t op, logic [`RV_XLEN-1:0] v,
			logic [2:0] n);
		case (op)
			alu_sll: return v << n;
			alu_srl: return v >> n;
			default: return $signed(v) >>> n;
		endcase
	endfunction

	assign is_shift = alu_op inside {alu_sll, alu_srl, alu_sra};

	always_comb begin
		alu_out = '0;
		case (alu_op)
			alu_sub: alu_out = op_a - op_b;
			alu_xor: alu_out = op_a ^ op_b;
			alu_or: alu_out = op_a | op_b;
			alu_and: alu_out = op_a & op_b;
			// Compares land in bit 0
			alu_slt: alu_out[0] = $signed(op_a) < $signed(op_b);
			alu_sltu: alu_out[0] = op_a < op_b;
			alu_eq: alu_out[0] = op_a == op_b;
			alu_ne: alu_out[0] = op_a != op_b;
			alu_ge: alu_out[0] = $signed(op_a) >= $signed(op_b);
			alu_geu: alu_out[0] = op_a >= op_b;
			default: alu_out = op_a + op_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			shifting <= 1'b0;
			ex_done <= 1'b0;
		end else begin
			ex_done <= 1'b0;
			if (ex_start && is_shift) begin
				shifting <= 1'b1;
			end else if (ex_start) begin
				ex_done <= 1'b1;
			end else if (shifting && sh_cnt == '0) begin
				shifting <= 1'b0;
				ex_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ex_start) begin
			sh_val <= op_a;
			sh_cnt <= op_b[4:0];
			sh_op <= alu_op;
			if (!is_shift)
				result <= alu_out;
		end else if (shifting) begin
			if (sh_cnt == '0) begin
				result <= sh_val;
			end else if (sh_cnt >= 5'd4) begin
				sh_val <= shift_by(sh_op, sh_val, 3'd4);
				sh_cnt <= sh_cnt - 5'd4;
			end else begin
				sh_val <= shift_by(sh_op, sh_val, 3'd1);
				sh_cnt <= sh_cnt - 5'd1;
			end
		end
	end

endmodule

//--- design/rv_regfile.sv
// Integer register file
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_regfile (
	input logic clk,
	input logic [`RV_REG_BITS-1:0] rs1,
	input logic [`RV_REG_BITS-1:0] rs2,
	output logic [`RV_XLEN-1:0] rs1_data,
	output logic [`RV_XLEN-1:0] rs2_data,
	input logic we,
	input logic [`RV_REG_BITS-1:0] rd,
	input logic [`RV_XLEN-1:0] rd_data
);
	logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

	// x0 always reads as zero
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

	always_ff @(posedge clk) begin
		if (we && rd != '0)
			regs[rd] <= rd_data;
	end

endmodule

//--- design/rv_decoder.sv
// Instruction decoder
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_decoder import rv_core_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic fetch_done,
	input logic [`RV_XLEN-1:0] fetched_word,
	output logic dec_valid,
	output dec_instr_t dec
);
	logic [`RV_XLEN-1:0] word_q;
	logic [6:0] opcode;
	logic [2:0] f3;
	logic [6:0] f7;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_s;
	logic [`RV_XLEN-1:0] imm_b;
	logic [`RV_XLEN-1:0] imm_u;
	logic [`RV_XLEN-1:0] imm_j;

	function automatic alu_op_t alu_from_f3(logic [2:0] f, logic alt);
		case (f)
			3'd0: return alt ? alu_sub : alu_add;
			3'd1: return alu_sll;
			3'd2: return alu_slt;
			3'd3: return alu_sltu;
			3'd4: return alu_xor;
			3'd5: return alt ? alu_sra : alu_srl;
			3'd6: return alu_or;
			default: return alu_and;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!resetn)
			dec_valid <= 1'b0;
		else
			dec_valid <= fetch_done;
	end

	always_ff @(posedge clk) begin
		if (fetch_done)
			word_q <= fetched_word;
	end

	assign opcode = word_q[6:0];
	assign f3 = word_q[14:12];
	assign f7 = word_q[31:25];

	assign imm_i = {{20{word_q[31]}}, word_q[31:20]};
	assign imm_s = {{20{word_q[31]}}, word_q[31:25], word_q[11:7]};
	assign imm_b = {{19{word_q[31]}}, word_q[31], word_q[7], word_q[30:25], word_q[11:8], 1'b0};
	assign imm_u = {word_q[31:12], 12'b0};
	assign imm_j = {{11{word_q[31]}}, word_q[31], word_q[19:12], word_q[20], word_q[30:21], 1'b0};

	always_comb begin
		dec = '0;
		dec.kind = kind_illegal;
		dec.alu_op = alu_add;
		dec.rd = word_q[11:7];
		dec.rs1 = word_q[19:15];
		dec.rs2 = word_q[24:20];
		dec.load_unsigned = f3[2];
		case (f3[1:0])
			2'd0: dec.mem_size = size_byte;
			2'd1: dec.mem_size = size_half;
			default: dec.mem_size = size_word;
		endcase
		case (opcode)
			`RV_OPC_LUI, `RV_OPC_AUIPC: begin
				dec.kind = (opcode == `RV_OPC_LUI) ? kind_lui : kind_auipc;
				dec.use_imm = 1'b1;
				dec.imm = imm_u;
			end
			`RV_OPC_JAL: begin
				dec.kind = kind_jal;
				dec.imm = imm_j;
			end
			`RV_OPC_JALR: begin
				if (f3 == 3'd0) dec.kind = kind_jalr;
				dec.use_imm = 1'b1;
				dec.imm = imm_i;
			end
			`RV_OPC_BRANCH: begin
				dec.imm = imm_b;
				dec.kind = kind_branch;
				case (f3)
					3'd0: dec.alu_op = alu_eq;
					3'd1: dec.alu_op = alu_ne;
					3'd4: dec.alu_op = alu_slt;
					3'd5: dec.alu_op = alu_ge;
					3'd6: dec.alu_op = alu_sltu;
					3'd7: dec.alu_op = alu_geu;
					default: dec.kind = kind_illegal;
				endcase
			end
			`RV_OPC_LOAD: begin
				if (f3 != 3'd3 && f3 <= 3'd5) dec.kind = kind_load;
				dec.use_imm = 1'b1;
				dec.imm = imm_i;
			end
			`RV_OPC_STORE: begin
				if (f3 <= 3'd2) dec.kind = kind_store;
				dec.use_imm = 1'b1;
				dec.imm = imm_s;
			end
			`RV_OPC_OPIMM: begin
				dec.use_imm = 1'b1;
				dec.imm = imm_i;
				dec.alu_op = alu_from_f3(f3, f3 == 3'd5 && f7 == `RV_F7_ALT);
				// Shift immediates carry a funct7 as well
				if ((f3 != 3'd1 && f3 != 3'd5) || f7 == `RV_F7_BASE ||
						(f3 == 3'd5 && f7 == `RV_F7_ALT))
					dec.kind = kind_alu;
			end
			`RV_OPC_OP: begin
				dec.alu_op = alu_from_f3(f3, f7 == `RV_F7_ALT);
				if (f7 == `RV_F7_BASE || (f7 == `RV_F7_ALT && (f3 == 3'd0 || f3 == 3'd5)))
					dec.kind = kind_alu;
			end
			`RV_OPC_FENCE: if (f3 == 3'd0) dec.kind = kind_fence;
			default: dec.kind = kind_illegal;
		endcase
	end

endmodule

//--- design/rv_mem_port.sv
// Native memory port sequencer
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_mem_port import rv_core_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic cmd_start,
	input mem_cmd_t cmd,
	output logic busy,
	output logic done,
	output logic fetch_done,
	output logic [`RV_XLEN-1:0] rdata,
	output logic mem_valid,
	output mem_req_t mem_req,
	input logic mem_ready,
	input logic [`RV_XLEN-1:0] mem_rdata
);
	typedef enum logic {mp_idle, mp_wait} mp_state_t;

	mp_state_t state;
	mem_cmd_t cur;
	mem_req_t req_next;
	logic complete;
	logic [15:0] lane_half;
	logic [7:0] lane_byte;
	logic [`RV_XLEN-1:0] load_value;

	assign mem_valid = (state == mp_wait);
	assign busy = (state != mp_idle);
	assign complete = mem_valid && mem_ready;

	// Store data goes out on every lane, strobes pick the bytes
	always_comb begin
		req_next.instr = (cmd.sel == sel_fetch);
		req_next.addr = {cmd.addr[`RV_XLEN-1:2], 2'b00};
		req_next.wdata = cmd.wdata;
		req_next.wstrb = '0;
		if (cmd.sel == sel_store) begin
			case (cmd.mem_size)
				size_byte: begin
					req_next.wdata = {4{cmd.wdata[7:0]}};
					req_next.wstrb = 4'b0001 << cmd.addr[1:0];
				end
				size_half: begin
					req_next.wdata = {2{cmd.wdata[15:0]}};
					req_next.wstrb = cmd.addr[1] ? 4'b1100 : 4'b0011;
				end
				default: req_next.wstrb = 4'b1111;
			endcase
		end
	end

	assign lane_half = cur.addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];
	assign lane_byte = mem_rdata[8*cur.addr[1:0] +: 8];

	always_comb begin
		case (cur.mem_size)
			size_byte: load_value = cur.load_unsigned ? {24'b0, lane_byte} :
				{{24{lane_byte[7]}}, lane_byte};
			size_half: load_value = cur.load_unsigned ? {16'b0, lane_half} :
				{{16{lane_half[15]}}, lane_half};
			default: load_value = mem_rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= mp_idle;
			done <= 1'b0;
			fetch_done <= 1'b0;
		end else begin
			done <= 1'b0;
			fetch_done <= 1'b0;
			case (state)
				mp_idle: if (cmd_start) state <= mp_wait;
				default: begin
					if (mem_ready) begin
						state <= mp_idle;
						done <= 1'b1;
						fetch_done <= (cur.sel == sel_fetch);
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == mp_idle && cmd_start) begin
			cur <= cmd;
			mem_req <= req_next;
		end
		if (complete)
			rdata <= load_value;
	end

endmodule

//--- design/rv_core_pkg.sv
// Core shared types
`include "rv_core_cfg.svh"

package rv_core_pkg;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu,
		alu_xor, alu_or, alu_and, alu_eq, alu_ne, alu_ge, alu_geu
	} alu_op_t;

	typedef enum logic [3:0] {
		kind_alu, kind_lui, kind_auipc, kind_jal, kind_jalr,
		kind_branch, kind_load, kind_store, kind_fence, kind_illegal
	} instr_kind_t;

	typedef enum logic [1:0] {
		size_word, size_half, size_byte
	} mem_size_t;

	typedef enum logic [1:0] {
		sel_fetch, sel_load, sel_store
	} mem_sel_t;

	typedef struct packed {
		instr_kind_t kind;
		alu_op_t alu_op;
		logic use_imm;
		logic [`RV_REG_BITS-1:0] rd;
		logic [`RV_REG_BITS-1:0] rs1;
		logic [`RV_REG_BITS-1:0] rs2;
		logic [`RV_XLEN-1:0] imm;
		mem_size_t mem_size;
		logic load_unsigned;
	} dec_instr_t;

	// One access as seen by the control FSM
	typedef struct packed {
		mem_sel_t sel;
		logic [`RV_XLEN-1:0] addr;
		logic [`RV_XLEN-1:0] wdata;
		mem_size_t mem_size;
		logic load_unsigned;
	} mem_cmd_t;

	typedef struct packed {
		logic instr;
		logic [`RV_XLEN-1:0] addr;
		logic [`RV_XLEN-1:0] wdata;
		logic [`RV_XLEN/8-1:0] wstrb;
	} mem_req_t;

endpackage

//--- design/rv_core_cfg.svh
// Core configuration constants
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

`define RV_XLEN      32
`define RV_NUM_REGS  32
`define RV_REG_BITS  5
`define RV_PC_STEP   4

// Major opcodes
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111
`define RV_OPC_BRANCH 7'b1100011
`define RV_OPC_LOAD   7'b0000011
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_OPIMM  7'b0010011
`define RV_OPC_OP     7'b0110011
`define RV_OPC_FENCE  7'b0001111

`define RV_F7_BASE 7'b0000000
`define RV_F7_ALT  7'b0100000

`endif
